//--- Bender.yml
package:
  name: priv_unit

sources:
  - src/priv_pkg.sv
  - src/priv_csr_if.sv
  - src/priv_ext_if.sv
  - src/priv_csr_file.sv
  - src/priv_trap_ctrl.sv
  - src/priv_pma_regs.sv
  - src/priv_unit.sv
  - target: test
    files:
      - tb/priv_unit_tb.sv

//--- compile.f
src/priv_pkg.sv
src/priv_csr_if.sv
src/priv_ext_if.sv
src/priv_csr_file.sv
src/priv_trap_ctrl.sv
src/priv_pma_regs.sv
src/priv_unit.sv
tb/priv_unit_tb.sv

//--- src/priv_csr_file.sv
// Machine CSR file
`timescale 1ns/10ps
`default_nettype none

module priv_csr_file (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   csr_addr,
  input  priv_pkg::csr_op_t     csr_op,
  input  priv_pkg::csr_data_t   csr_wdata,
  input  priv_pkg::priv_level_t curr_priv,
  input  logic                  inst_ret,
  output priv_pkg::csr_data_t   csr_rdata,
  output logic                  csr_invalid,
  priv_csr_if.csr               prv,
  priv_ext_if.csr               ext
);

  priv_pkg::csr_data_t mstatus, mstatus_next;
  priv_pkg::csr_data_t mie, mie_next;
  priv_pkg::csr_data_t mip, mip_next;
  priv_pkg::csr_data_t mtvec, mtvec_next;
  priv_pkg::csr_data_t mscratch, mscratch_next;
  priv_pkg::csr_data_t mepc, mepc_next;
  priv_pkg::csr_data_t mcause, mcause_next;
  priv_pkg::csr_data_t mtval, mtval_next;
  priv_pkg::csr_data_t mcounteren, mcounteren_next;
  priv_pkg::csr_data_t mcountinhibit, mcountinhibit_next;
  priv_pkg::long_csr_t cycle_cnt, cycle_next;
  priv_pkg::long_csr_t instret_cnt, instret_next;

  priv_pkg::csr_data_t old_val, new_val;
  priv_pkg::csr_data_t mstatus_wr, mtvec_wr;
  logic [1:0]          wr_mpp, wr_mode;
  logic                addr_known, priv_fail, addr_fail, wr_en;

  // Privilege and address checks
  assign priv_fail = (csr_op != priv_pkg::CSR_NONE) && (csr_addr[9:8] > curr_priv);
  assign addr_fail = (csr_op != priv_pkg::CSR_NONE) && !addr_known && !ext.ack;
  assign csr_invalid = priv_fail | addr_fail | ext.invalid_csr;
  assign wr_en = (csr_op != priv_pkg::CSR_NONE) && !csr_invalid;
  assign csr_rdata = old_val;

  assign ext.csr_addr = csr_addr;
  assign ext.value_in = new_val;
  assign ext.csr_active = (csr_op != priv_pkg::CSR_NONE) && !priv_fail;

  always_comb begin
    case (csr_op)
      priv_pkg::CSR_SET:   new_val = old_val | csr_wdata;
      priv_pkg::CSR_CLEAR: new_val = old_val & ~csr_wdata;
      default:             new_val = csr_wdata;
    endcase
  end

  // WARL legalization
  assign wr_mpp = new_val[priv_pkg::MPP_LSB +: 2];
  assign wr_mode = new_val[1:0];

  always_comb begin
    mstatus_wr = '0;
    mstatus_wr[priv_pkg::MIE_BIT] = new_val[priv_pkg::MIE_BIT];
    mstatus_wr[priv_pkg::MPIE_BIT] = new_val[priv_pkg::MPIE_BIT];
    // Reserved and S encodings collapse to U
    mstatus_wr[priv_pkg::MPP_LSB +: 2] = (wr_mpp == priv_pkg::M_MODE) ? priv_pkg::M_MODE
                                                                       : priv_pkg::U_MODE;
    mtvec_wr = {new_val[31:2], wr_mode};
    if (wr_mode > priv_pkg::VECTORED) begin
      mtvec_wr[1:0] = priv_pkg::DIRECT;
    end
  end

  always_comb begin
    mstatus_next = mstatus;
    mie_next = mie;
    mip_next = mip;
    mtvec_next = mtvec;
    mscratch_next = mscratch;
    mepc_next = mepc;
    mcause_next = mcause;
    mtval_next = mtval;
    mcounteren_next = mcounteren;
    mcountinhibit_next = mcountinhibit;
    cycle_next = cycle_cnt;
    instret_next = instret_cnt;

    if (!mcountinhibit[priv_pkg::CY_BIT]) begin
      cycle_next = cycle_cnt + 64'd1;
    end
    if (!mcountinhibit[priv_pkg::IR_BIT]) begin
      instret_next = instret_cnt + {63'd0, inst_ret};
    end

    // Read-only addresses fall through untouched
    if (wr_en) begin
      case (csr_addr)
        priv_pkg::MSTATUS_ADDR:       mstatus_next = mstatus_wr;
        priv_pkg::MIE_ADDR:           mie_next = new_val & priv_pkg::IRQ_MASK;
        priv_pkg::MIP_ADDR:           mip_next = new_val & priv_pkg::IRQ_MASK;
        priv_pkg::MTVEC_ADDR:         mtvec_next = mtvec_wr;
        priv_pkg::MSCRATCH_ADDR:      mscratch_next = new_val;
        priv_pkg::MEPC_ADDR:          mepc_next = {new_val[31:2], 2'b00};
        priv_pkg::MCAUSE_ADDR:        mcause_next = new_val;
        priv_pkg::MTVAL_ADDR:         mtval_next = new_val;
        priv_pkg::MCOUNTEREN_ADDR:    mcounteren_next = new_val;
        priv_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit_next = new_val & priv_pkg::INHIBIT_MASK;
        priv_pkg::MCYCLE_ADDR:        cycle_next[31:0] = new_val;
        priv_pkg::MCYCLEH_ADDR:       cycle_next[63:32] = new_val;
        priv_pkg::MINSTRET_ADDR:      instret_next[31:0] = new_val;
        priv_pkg::MINSTRETH_ADDR:     instret_next[63:32] = new_val;
        default: ;
      endcase
    end

    // Trap controller overrides
    if (prv.inject_mstatus) mstatus_next = prv.next_mstatus;
    if (prv.inject_mepc)    mepc_next = prv.next_mepc;
    if (prv.inject_mcause)  mcause_next = prv.next_mcause;
    if (prv.inject_mtval)   mtval_next = prv.next_mtval;
    if (prv.inject_mip)     mip_next = prv.next_mip;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus <= priv_pkg::MSTATUS_RESET;
      mie <= '0;
      mip <= '0;
      mtvec <= '0;
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
      mcounteren <= '0;
      mcountinhibit <= '0;
      cycle_cnt <= '0;
      instret_cnt <= '0;
    end else begin
      mstatus <= mstatus_next;
      mie <= mie_next;
      mip <= mip_next;
      mtvec <= mtvec_next;
      mscratch <= mscratch_next;
      mepc <= mepc_next;
      mcause <= mcause_next;
      mtval <= mtval_next;
      mcounteren <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
      cycle_cnt <= cycle_next;
      instret_cnt <= instret_next;
    end
  end

  // Readback with extensions answering unknown addresses
  always_comb begin
    old_val = '0;
    addr_known = 1'b1;
    case (csr_addr)
      priv_pkg::MSTATUS_ADDR:       old_val = mstatus;
      priv_pkg::MISA_ADDR:          old_val = priv_pkg::MISA_VALUE;
      priv_pkg::MIE_ADDR:           old_val = mie;
      priv_pkg::MIP_ADDR:           old_val = mip;
      priv_pkg::MTVEC_ADDR:         old_val = mtvec;
      priv_pkg::MSCRATCH_ADDR:      old_val = mscratch;
      priv_pkg::MEPC_ADDR:          old_val = mepc;
      priv_pkg::MCAUSE_ADDR:        old_val = mcause;
      priv_pkg::MTVAL_ADDR:         old_val = mtval;
      priv_pkg::MCOUNTEREN_ADDR:    old_val = mcounteren;
      priv_pkg::MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      priv_pkg::MCYCLE_ADDR:        old_val = cycle_cnt[31:0];
      priv_pkg::MCYCLEH_ADDR:       old_val = cycle_cnt[63:32];
      priv_pkg::MINSTRET_ADDR:      old_val = instret_cnt[31:0];
      priv_pkg::MINSTRETH_ADDR:     old_val = instret_cnt[63:32];
      priv_pkg::MHARTID_ADDR:       old_val = priv_pkg::HARTID;
      priv_pkg::MVENDORID_ADDR,
      priv_pkg::MARCHID_ADDR,
      priv_pkg::MIMPID_ADDR:        old_val = '0; // Unimplemented IDs read zero
      default: begin
        addr_known = 1'b0;
        if (ext.ack) begin
          old_val = ext.value_out;
        end
      end
    endcase
  end

  assign prv.curr_mstatus = mstatus;
  assign prv.curr_mie = mie;
  assign prv.curr_mip = mip;
  assign prv.curr_mtvec = mtvec;
  assign prv.curr_mepc = mepc;

endmodule

`default_nettype wire

//--- src/priv_csr_if.sv
// CSR file to trap controller link
`timescale 1ns/10ps
`default_nettype none

interface priv_csr_if;

  // Current register values
  priv_pkg::csr_data_t curr_mstatus;
  priv_pkg::csr_data_t curr_mie;
  priv_pkg::csr_data_t curr_mip;
  priv_pkg::csr_data_t curr_mtvec;
  priv_pkg::csr_data_t curr_mepc;

  // Hardware overrides that win over CSR writes
  logic inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  priv_pkg::csr_data_t next_mstatus;
  priv_pkg::csr_data_t next_mepc;
  priv_pkg::csr_data_t next_mcause;
  priv_pkg::csr_data_t next_mtval;
  priv_pkg::csr_data_t next_mip;

  modport csr (
    output curr_mstatus, curr_mie, curr_mip, curr_mtvec, curr_mepc,
    input  inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip,
    input  next_mstatus, next_mepc, next_mcause, next_mtval, next_mip
  );

  modport trap (
    input  curr_mstatus, curr_mie, curr_mip, curr_mtvec, curr_mepc,
    output inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip,
    output next_mstatus, next_mepc, next_mcause, next_mtval, next_mip
  );

endinterface

`default_nettype wire

//--- src/priv_ext_if.sv
// Extension CSR broadcast
`timescale 1ns/10ps
`default_nettype none

interface priv_ext_if;

  priv_pkg::csr_addr_t csr_addr;
  priv_pkg::csr_data_t value_in;   // Combined new value
  logic                csr_active;
  logic                ack;        // Extension owns csr_addr
  logic                invalid_csr;
  priv_pkg::csr_data_t value_out;

  modport csr (
    output csr_addr, value_in, csr_active,
    input  ack, invalid_csr, value_out
  );

  modport ext (
    input  csr_addr, value_in, csr_active,
    output ack, invalid_csr, value_out
  );

endinterface

`default_nettype wire

//--- src/priv_pkg.sv
// Privilege unit definitions
`default_nettype none

package priv_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [63:0] long_csr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } mtvec_mode_t;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  localparam csr_addr_t PMA_REGION0_ADDR   = 12'h7C0; // Custom range
  localparam csr_addr_t PMA_REGION1_ADDR   = 12'h7C1;
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;

  // Field positions in mstatus, mie and mip
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;
  localparam int MPP_LSB  = 11;
  localparam int MSI_BIT  = 3;
  localparam int MTI_BIT  = 7;
  localparam int MEI_BIT  = 11;
  localparam int CY_BIT   = 0;  // mcountinhibit
  localparam int IR_BIT   = 2;
  localparam int PMA_LOCK_BIT = 31;

  localparam csr_data_t MISA_VALUE      = 32'h4010_0100; // MXL=1, U and I
  localparam csr_data_t CAUSE_IRQ_SOFT  = 32'h8000_0003;
  localparam csr_data_t CAUSE_IRQ_TIMER = 32'h8000_0007;
  localparam csr_data_t CAUSE_IRQ_EXT   = 32'h8000_000B;
  localparam csr_data_t HARTID          = 32'd0;

  // Reset values and writable masks
  localparam csr_data_t MSTATUS_RESET = 32'h0000_1800; // mpp = M
  localparam csr_data_t IRQ_MASK =
    (32'd1 << MSI_BIT) | (32'd1 << MTI_BIT) | (32'd1 << MEI_BIT);
  localparam csr_data_t INHIBIT_MASK = (32'd1 << CY_BIT) | (32'd1 << IR_BIT);

endpackage

`default_nettype wire

//--- src/priv_pma_regs.sv
// Lockable memory attribute regions
`timescale 1ns/10ps
`default_nettype none

module priv_pma_regs (
  input logic     CLK,
  input logic     nRST,
  priv_ext_if.ext ext
);

  priv_pkg::csr_data_t region [0:1];
  priv_pkg::csr_data_t stored;
  logic                hit, sel, locked;

  assign sel = ext.csr_addr[0]; // 0x7C0 or 0x7C1
  assign hit = ext.csr_active && ((ext.csr_addr == priv_pkg::PMA_REGION0_ADDR) ||
                                  (ext.csr_addr == priv_pkg::PMA_REGION1_ADDR));
  assign stored = region[sel];
  assign locked = stored[priv_pkg::PMA_LOCK_BIT];

  assign ext.ack = hit;
  assign ext.value_out = stored;
  // Locked entry refuses any change but lets a plain read pass
  assign ext.invalid_csr = hit && locked && (ext.value_in != stored);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      region[0] <= '0;
      region[1] <= '0;
    end else if (hit && !locked) begin
      region[sel] <= ext.value_in;
    end
  end

endmodule

`default_nettype wire

//--- src/priv_trap_ctrl.sv
// Trap and interrupt controller
`timescale 1ns/10ps
`default_nettype none

module priv_trap_ctrl (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  exc_req,
  input  priv_pkg::csr_data_t   exc_cause,
  input  priv_pkg::csr_data_t   exc_epc,
  input  priv_pkg::csr_data_t   exc_tval,
  input  logic                  mret,
  input  priv_pkg::priv_level_t curr_priv,
  input  logic                  irq_ext,
  input  logic                  irq_timer,
  input  logic                  irq_soft,
  input  logic                  irq_take,
  output logic                  irq_req,
  output priv_pkg::csr_data_t   trap_pc,
  priv_csr_if.trap              prv
);

  priv_pkg::csr_data_t irq_lines, irq_lines_q, irq_pend, irq_cause;
  priv_pkg::csr_data_t trap_base, trap_mstatus, mret_mstatus;
  logic                take_exc, take_irq, do_mret;

  always_comb begin
    irq_lines = '0;
    irq_lines[priv_pkg::MSI_BIT] = irq_soft;
    irq_lines[priv_pkg::MTI_BIT] = irq_timer;
    irq_lines[priv_pkg::MEI_BIT] = irq_ext;
  end

  // Last sampled lines so mip is refreshed only when one changes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      irq_lines_q <= '0;
    end else begin
      irq_lines_q <= irq_lines;
    end
  end

  assign prv.inject_mip = (irq_lines != irq_lines_q);
  assign prv.next_mip = irq_lines;

  assign irq_pend = prv.curr_mip & prv.curr_mie & priv_pkg::IRQ_MASK;
  assign irq_req = (|irq_pend) & prv.curr_mstatus[priv_pkg::MIE_BIT];

  always_comb begin
    if (irq_pend[priv_pkg::MEI_BIT]) irq_cause = priv_pkg::CAUSE_IRQ_EXT;
    else if (irq_pend[priv_pkg::MSI_BIT]) irq_cause = priv_pkg::CAUSE_IRQ_SOFT;
    else irq_cause = priv_pkg::CAUSE_IRQ_TIMER;
  end

  // Exception beats interrupt beats mret
  assign take_exc = exc_req;
  assign take_irq = !exc_req && irq_take && irq_req;
  assign do_mret = !exc_req && !take_irq && mret;

  always_comb begin
    trap_mstatus = prv.curr_mstatus;
    trap_mstatus[priv_pkg::MPIE_BIT] = prv.curr_mstatus[priv_pkg::MIE_BIT];
    trap_mstatus[priv_pkg::MIE_BIT] = 1'b0;
    trap_mstatus[priv_pkg::MPP_LSB +: 2] = curr_priv;
    mret_mstatus = prv.curr_mstatus;
    mret_mstatus[priv_pkg::MIE_BIT] = prv.curr_mstatus[priv_pkg::MPIE_BIT];
    mret_mstatus[priv_pkg::MPIE_BIT] = 1'b1;
    mret_mstatus[priv_pkg::MPP_LSB +: 2] = priv_pkg::U_MODE;
  end

  assign prv.inject_mstatus = take_exc | take_irq | do_mret;
  assign prv.next_mstatus = do_mret ? mret_mstatus : trap_mstatus;
  assign prv.inject_mepc = take_exc | take_irq;
  assign prv.next_mepc = exc_epc;
  assign prv.inject_mcause = take_exc | take_irq;
  assign prv.next_mcause = take_exc ? exc_cause : irq_cause;
  assign prv.inject_mtval = take_exc | take_irq;
  assign prv.next_mtval = take_exc ? exc_tval : '0; // Interrupts carry no tval

  assign trap_base = {prv.curr_mtvec[31:2], 2'b00};

  always_comb begin
    if (do_mret) begin
      trap_pc = prv.curr_mepc;
    end else if (!exc_req && irq_req && (prv.curr_mtvec[1:0] == priv_pkg::VECTORED)) begin
      trap_pc = trap_base + {irq_cause[29:0], 2'b00};
    end else begin
      trap_pc = trap_base; // Exceptions are always direct
    end
  end

endmodule

`default_nettype wire

//--- src/priv_unit.sv
// Machine-mode privilege unit
`timescale 1ns/10ps
`default_nettype none

module priv_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   csr_addr,
  input  priv_pkg::csr_op_t     csr_op,
  input  priv_pkg::csr_data_t   csr_wdata,
  input  priv_pkg::priv_level_t curr_priv,
  input  logic                  inst_ret,
  output priv_pkg::csr_data_t   csr_rdata,
  output logic                  csr_invalid,
  input  logic                  exc_req,
  input  priv_pkg::csr_data_t   exc_cause,
  input  priv_pkg::csr_data_t   exc_epc,
  input  priv_pkg::csr_data_t   exc_tval,
  input  logic                  mret,
  input  logic                  irq_ext,
  input  logic                  irq_timer,
  input  logic                  irq_soft,
  input  logic                  irq_take,
  output logic                  irq_req,
  output priv_pkg::csr_data_t   trap_pc
);

  priv_csr_if prv_if ();
  priv_ext_if ext_if ();

  priv_csr_file csr_file_i (
    .CLK, .nRST, .csr_addr, .csr_op, .csr_wdata, .curr_priv, .inst_ret,
    .csr_rdata, .csr_invalid,
    .prv (prv_if.csr),
    .ext (ext_if.csr)
  );

  priv_trap_ctrl trap_ctrl_i (
    .CLK, .nRST, .exc_req, .exc_cause, .exc_epc, .exc_tval, .mret, .curr_priv,
    .irq_ext, .irq_timer, .irq_soft, .irq_take, .irq_req, .trap_pc,
    .prv (prv_if.trap)
  );

  priv_pma_regs pma_regs_i (
    .CLK, .nRST,
    .ext (ext_if.ext)
  );

endmodule

`default_nettype wire

//--- tb/priv_unit_tb.sv
// Privilege unit testbench
`timescale 1ns/10ps
`default_nettype none

module priv_unit_tb;

  typedef struct packed {
    priv_pkg::csr_op_t     op;
    priv_pkg::csr_addr_t   addr;
    priv_pkg::csr_data_t   data;    // Also drives exc_epc
    priv_pkg::priv_level_t priv;
    logic [2:0]            trap;    // exc, mret, irq_take
    logic [1:0]            mode;    // Random data and shadow model flags
    priv_pkg::csr_data_t   exp_rd;
    logic                  exp_inv;
    priv_pkg::csr_data_t   exp_pc;  // Checked on trap rows only
  } row_t;

  localparam int NUM_ROWS = 26;
  localparam int IRQ_TIMEOUT = 10;
  localparam priv_pkg::csr_op_t NOP = priv_pkg::CSR_NONE;
  localparam priv_pkg::csr_op_t WR = priv_pkg::CSR_WRITE;
  localparam priv_pkg::csr_op_t SET = priv_pkg::CSR_SET;
  localparam priv_pkg::csr_op_t CLR = priv_pkg::CSR_CLEAR;
  localparam priv_pkg::priv_level_t PM = priv_pkg::M_MODE;
  localparam priv_pkg::priv_level_t PU = priv_pkg::U_MODE;
  localparam logic [2:0] T_NONE = 3'b000;
  localparam logic [2:0] T_EXC = 3'b100;
  localparam logic [2:0] T_RET = 3'b010;
  localparam logic [2:0] T_TAKE = 3'b001;
  localparam logic [1:0] FIX = 2'b00;
  localparam logic [1:0] MDL = 2'b01;
  localparam logic [1:0] RND = 2'b11;
  localparam priv_pkg::csr_data_t EXC_CAUSE = 32'd2; // Illegal instruction
  localparam priv_pkg::csr_data_t EXC_TVAL = 32'h0000_0BAD;

  logic                  CLK, nRST;
  priv_pkg::csr_addr_t   csr_addr;
  priv_pkg::csr_op_t     csr_op;
  priv_pkg::csr_data_t   csr_wdata, csr_rdata;
  priv_pkg::priv_level_t curr_priv;
  logic                  inst_ret, csr_invalid, exc_req, mret;
  priv_pkg::csr_data_t   exc_cause, exc_epc, exc_tval, trap_pc;
  logic                  irq_ext, irq_timer, irq_soft, irq_take, irq_req;

  row_t                rows [0:NUM_ROWS-1];
  priv_pkg::csr_data_t scratch_model;

  priv_unit dut_i (.*);

  always #20 CLK = ~CLK;

  task automatic stop_on_error();
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp, got);
      stop_on_error();
    end
  endtask

  task automatic apply_row(input row_t r);
    priv_pkg::csr_data_t wdata;
    priv_pkg::csr_data_t exp;
    wdata = r.mode[1] ? $urandom : r.data;
    exp = r.mode[0] ? scratch_model : r.exp_rd;
    @(posedge CLK);
    #2;
    csr_op = r.op;
    csr_addr = r.addr;
    csr_wdata = wdata;
    curr_priv = r.priv;
    exc_epc = r.data;
    exc_req = r.trap[2];
    mret = r.trap[1];
    irq_take = r.trap[0];
    @(negedge CLK); // Mid-cycle when combinational outputs have settled
    expect_eq("csr_rdata", csr_rdata, exp);
    expect_eq("csr_invalid", {31'd0, csr_invalid}, {31'd0, r.exp_inv});
    if (|r.trap) expect_eq("trap_pc", trap_pc, r.exp_pc);
    // Shadow copy of mscratch
    if (r.mode[0] && !r.exp_inv) begin
      case (r.op)
        WR:  scratch_model = wdata;
        SET: scratch_model = scratch_model | wdata;
        CLR: scratch_model = scratch_model & ~wdata;
        default: ;
      endcase
    end
  endtask

  task automatic go_idle();
    @(posedge CLK);
    #2;
    csr_op = NOP;
    exc_req = 1'b0;
    mret = 1'b0;
    irq_take = 1'b0;
    inst_ret = 1'b0;
  endtask

  task automatic read_csr(input priv_pkg::csr_addr_t addr, output priv_pkg::csr_data_t value);
    go_idle();
    csr_op = SET;
    csr_addr = addr;
    csr_wdata = '0;
    curr_priv = PM;
    @(negedge CLK);
    expect_eq("csr_invalid", {31'd0, csr_invalid}, 32'd0);
    value = csr_rdata;
  endtask

  task automatic load_table();
    // mscratch access ops against the shadow
    rows[0]  = '{WR,  priv_pkg::MSCRATCH_ADDR, 32'h0, PM, T_NONE, RND, '0, 1'b0, '0};
    rows[1]  = '{SET, priv_pkg::MSCRATCH_ADDR, 32'h0, PM, T_NONE, RND, '0, 1'b0, '0};
    rows[2]  = '{CLR, priv_pkg::MSCRATCH_ADDR, 32'h0, PM, T_NONE, RND, '0, 1'b0, '0};
    rows[3]  = '{SET, priv_pkg::MSCRATCH_ADDR, 32'h0, PM, T_NONE, MDL, '0, 1'b0, '0};
    rows[4]  = '{WR,  priv_pkg::MSCRATCH_ADDR, 32'h0, PU, T_NONE, RND, '0, 1'b1, '0};
    rows[5]  = '{SET, priv_pkg::MSCRATCH_ADDR, 32'h0, PM, T_NONE, MDL, '0, 1'b0, '0};
    rows[6]  = '{WR,  12'h7FF, 32'h0, PM, T_NONE, FIX, '0, 1'b1, '0}; // Nobody owns it
    rows[7]  = '{WR,  priv_pkg::MHARTID_ADDR, 32'hDEAD_BEEF, PM, T_NONE, FIX, '0, 1'b0, '0};
    rows[8]  = '{SET, priv_pkg::MHARTID_ADDR, 32'h0, PM, T_NONE, FIX, '0, 1'b0, '0};
    // WARL fields
    rows[9]  = '{WR,  priv_pkg::MSTATUS_ADDR, 32'h1000, PM, T_NONE, FIX, 32'h1800, 1'b0, '0};
    rows[10] = '{SET, priv_pkg::MSTATUS_ADDR, 32'h0, PM, T_NONE, FIX, 32'h0, 1'b0, '0};
    rows[11] = '{WR,  priv_pkg::MTVEC_ADDR, 32'h1003, PM, T_NONE, FIX, 32'h0, 1'b0, '0};
    rows[12] = '{SET, priv_pkg::MTVEC_ADDR, 32'h0, PM, T_NONE, FIX, 32'h1000, 1'b0, '0};
    // Exception entry and return
    rows[13] = '{WR,  priv_pkg::MSTATUS_ADDR, 32'h1808, PM, T_NONE, FIX, 32'h0, 1'b0, '0};
    rows[14] = '{NOP, priv_pkg::MSTATUS_ADDR, 32'h100, PM, T_EXC, FIX, 32'h1808, 1'b0, 32'h1000};
    rows[15] = '{SET, priv_pkg::MEPC_ADDR, 32'h0, PM, T_NONE, FIX, 32'h100, 1'b0, '0};
    rows[16] = '{SET, priv_pkg::MCAUSE_ADDR, 32'h0, PM, T_NONE, FIX, EXC_CAUSE, 1'b0, '0};
    rows[17] = '{SET, priv_pkg::MTVAL_ADDR, 32'h0, PM, T_NONE, FIX, EXC_TVAL, 1'b0, '0};
    rows[18] = '{SET, priv_pkg::MSTATUS_ADDR, 32'h0, PM, T_NONE, FIX, 32'h1880, 1'b0, '0};
    rows[19] = '{NOP, priv_pkg::MSTATUS_ADDR, 32'h0, PM, T_RET, FIX, 32'h1880, 1'b0, 32'h100};
    rows[20] = '{SET, priv_pkg::MSTATUS_ADDR, 32'h0, PM, T_NONE, FIX, 32'h0088, 1'b0, '0};
    // Region register and its lock
    rows[21] = '{WR,  priv_pkg::PMA_REGION0_ADDR, 32'hF5, PM, T_NONE, FIX, 32'h0, 1'b0, '0};
    rows[22] = '{SET, priv_pkg::PMA_REGION0_ADDR, 32'h0, PM, T_NONE, FIX, 32'hF5, 1'b0, '0};
    rows[23] = '{SET, priv_pkg::PMA_REGION0_ADDR, 32'h8000_0000, PM, T_NONE, FIX, 32'hF5, 1'b0, '0};
    rows[24] = '{WR,  priv_pkg::PMA_REGION0_ADDR, 32'h11, PM, T_NONE, FIX, 32'h8000_00F5, 1'b1, '0};
    rows[25] = '{SET, priv_pkg::PMA_REGION0_ADDR, 32'h0, PM, T_NONE, FIX, 32'h8000_00F5, 1'b0, '0};
  endtask

  initial begin
    priv_pkg::csr_data_t first, second;
    int n;
    int count;
    CLK = 1'b0;
    nRST = 1'b0;
    csr_op = NOP;
    csr_addr = '0;
    csr_wdata = '0;
    curr_priv = PM;
    inst_ret = 1'b0;
    exc_req = 1'b0;
    exc_cause = EXC_CAUSE;
    exc_epc = '0;
    exc_tval = EXC_TVAL;
    mret = 1'b0;
    irq_ext = 1'b0;
    irq_timer = 1'b0;
    irq_soft = 1'b0;
    irq_take = 1'b0;
    scratch_model = '0;
    void'($urandom(32'h6242_bf50));
    load_table();

    repeat (4) @(posedge CLK);
    #2 nRST = 1'b1;
    @(negedge CLK);
    expect_eq("irq_req", {31'd0, irq_req}, 32'd0);
    expect_eq("csr_invalid", {31'd0, csr_invalid}, 32'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end

    // Timer interrupt through a vectored mtvec
    apply_row('{WR, priv_pkg::MIE_ADDR, 32'h80, PM, T_NONE, FIX, 32'h0, 1'b0, '0});
    apply_row('{WR, priv_pkg::MTVEC_ADDR, 32'h2001, PM, T_NONE, FIX, 32'h1000, 1'b0, '0});
    go_idle();
    irq_timer = 1'b1;
    n = 0;
    while (!irq_req && n < IRQ_TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    assert (irq_req) else begin
      $display("irq_req did not rise within %0d cycles of irq_timer", IRQ_TIMEOUT);
      stop_on_error();
    end
    apply_row('{NOP, priv_pkg::MCAUSE_ADDR, 32'h240, PM, T_TAKE, FIX, EXC_CAUSE, 1'b0,
                32'h2000 + 32'd4 * 32'd7});
    apply_row('{SET, priv_pkg::MCAUSE_ADDR, 32'h0, PM, T_NONE, FIX, priv_pkg::CAUSE_IRQ_TIMER,
                1'b0, '0});
    expect_eq("irq_req", {31'd0, irq_req}, 32'd0); // mstatus.mie now clear
    apply_row('{SET, priv_pkg::MEPC_ADDR, 32'h0, PM, T_NONE, FIX, 32'h240, 1'b0, '0});
    go_idle();
    irq_timer = 1'b0;

    // Counters
    read_csr(priv_pkg::MCYCLE_ADDR, first);
    repeat (3) go_idle();
    read_csr(priv_pkg::MCYCLE_ADDR, second);
    assert (second > first) else begin
      $display("ERR %0t mcycle: expected above %h, got %h", $time, first, second);
      stop_on_error();
    end
    read_csr(priv_pkg::MINSTRET_ADDR, first);
    count = 0;
    for (int k = 0; k < 16; k++) begin
      go_idle();
      inst_ret = $urandom & 1;
      count += inst_ret;
    end
    read_csr(priv_pkg::MINSTRET_ADDR, second);
    expect_eq("minstret", second, first + count);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
